/* source/ulaVideoPkg.sv */
`default_nettype none

package ulaVideoPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Raster geometry, counted in character cells and lines
  ////////////////////////////////////////////////////////////////////////////
  localparam int CELLS_PER_LINE  = 64;
  localparam int VISIBLE_FIRST   = 1;    // First column with picture
  localparam int VISIBLE_LAST    = 40;
  localparam int HSYNC_FIRST     = 49;
  localparam int HSYNC_LAST      = 53;
  localparam int RELOAD_FIRST    = 49;   // Attributes back to defaults from here on
  localparam int LAST_LINE_60    = 260;  // 261 lines per frame
  localparam int LAST_LINE_50    = 312;  // 313 lines per frame
  localparam int VSYNC_60        = 241;  // First vsync line at 60 Hz
  localparam int VSYNC_50        = 258;  // First vsync line at 50 Hz
  localparam int VSYNC_LINES     = 2;
  localparam int VBLANK_FIRST    = 224;
  localparam int TEXT_FORCE_LINE = 199;  // Lines below this one are always text
  localparam int PIXELS_PER_CELL = 6;

  // Colour triple, red in the top bit
  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } rgbT;

  // One character cell as handed from fetcher to serializer
  typedef struct packed {
    logic [PIXELS_PER_CELL-1:0] pattern;  // Leftmost pixel in the MSB
    rgbT                        ink;
    rgbT                        paper;
    logic                       inverse;
    logic                       hsync;
    logic                       vsync;
    logic                       blank;
  } cellT;

  typedef struct packed {
    rgbT  rgb;
    logic hsync;
    logic vsync;
    logic blank;
  } pixelT;

endpackage

`default_nettype wire

/* source/ulaMemPkg.sv */
`default_nettype none

package ulaMemPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Video memory map
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [15:0] HIRES_BASE        = 16'hA000;
  localparam logic [15:0] TEXT_BASE         = 16'hBB80;

  // Glyph tables, 128 glyphs of 8 rows each
  localparam logic [15:0] CHARSET_TEXT_STD  = 16'hB400;
  localparam logic [15:0] CHARSET_TEXT_ALT  = 16'hB800;
  localparam logic [15:0] CHARSET_HIRES_STD = 16'h9800;  // Seen on the text rows of hires
  localparam logic [15:0] CHARSET_HIRES_ALT = 16'h9C00;

  localparam int          ROW_BYTES         = 40;        // Screen bytes per row

  // Read request towards video memory
  typedef struct packed {
    logic [15:0] addr;
  } memReqT;

endpackage

`default_nettype wire

/* source/rasterTimer.sv */
`timescale 1ns/100ps
`default_nettype none

module rasterTimer
  import ulaVideoPkg::*;
(
  input  wire        CLK_24,
  input  wire        RESET_INT,
  input  wire        step,        // One cell done
  input  wire        frame50,     // 313 line frame when set
  output logic [5:0] column,
  output logic [8:0] line,
  output logic       hsync,
  output logic       vsync,
  output logic       blank,
  output logic       reload,
  output logic       forceText,
  output logic       flashPhase
);

  logic [4:0] frameCnt;           // Frames since reset, wraps at 32
  logic       lineEnd;
  logic       frameEnd;
  logic [8:0] vsyncFirst;

  assign lineEnd  = (column == 6'(CELLS_PER_LINE - 1));
  // Compare with >= so a late switch to 60 Hz still wraps
  assign frameEnd = frame50 ? (line >= 9'(LAST_LINE_50)) : (line >= 9'(LAST_LINE_60));

  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      column   <= '0;
      line     <= '0;
      frameCnt <= '0;
    end else if (step) begin
      if (lineEnd) begin
        column <= '0;
        if (frameEnd) begin
          line     <= '0;
          frameCnt <= frameCnt + 5'd1;   // Flash counter
        end else begin
          line <= line + 9'd1;
        end
      end else begin
        column <= column + 6'd1;
      end
    end
  end

  // Window decodes
  assign vsyncFirst = frame50 ? 9'(VSYNC_50) : 9'(VSYNC_60);
  assign hsync      = (column >= 6'(HSYNC_FIRST)) && (column <= 6'(HSYNC_LAST));
  assign vsync      = (line >= vsyncFirst) && (line < vsyncFirst + 9'(VSYNC_LINES));
  assign blank      = (column < 6'(VISIBLE_FIRST)) || (column > 6'(VISIBLE_LAST)) ||
                      (line >= 9'(VBLANK_FIRST));
  assign reload     = (column >= 6'(RELOAD_FIRST));
  assign forceText  = (line > 9'(TEXT_FORCE_LINE));
  assign flashPhase = frameCnt[4];         // Toggles every 16 frames

endmodule

`default_nettype wire

/* source/cellFetcher.sv */
`timescale 1ns/100ps
`default_nettype none

module cellFetcher
  import ulaVideoPkg::*, ulaMemPkg::*;
(
  input  wire        CLK_24,
  input  wire        RESET_INT,
  output memReqT     memReq,
  output logic       memReqValid,
  input  wire        memReqReady,
  input  wire        memRspValid,
  input  wire  [7:0] memRspData,
  output cellT       cellIn,
  output logic       cellInValid,
  input  wire        cellInReady
);

  typedef enum logic [2:0] {
    ST_CELL,      // Blank cells are offered here, others request the screen byte
    ST_SCR_WAIT,
    ST_GLY_REQ,
    ST_GLY_WAIT,
    ST_OFFER
  } stateT;

  stateT       state;
  logic [5:0]  column;
  logic [8:0]  line;
  logic        hsync, vsync, blank, reload, forceText, flashPhase;
  logic        step;
  rgbT         inkReg, paperReg;
  logic [2:0]  styleReg;               // [0] alternate set, [1] double height, [2] flash
  logic [2:0]  modeReg;                // [1] 50 Hz, [2] hires
  logic [7:0]  scrByte;
  logic [5:0]  patReg;
  logic        hiresOn, isAttr, flashOff;
  logic [8:0]  rowIdx;
  logic [15:0] rowOffset, scrAddr, charBase, glyphAddr;
  logic [2:0]  glyphRow;

  assign step = cellInValid && cellInReady;

  rasterTimer u_raster (
    .CLK_24     (CLK_24),
    .RESET_INT  (RESET_INT),
    .step       (step),
    .frame50    (modeReg[1]),
    .column     (column),
    .line       (line),
    .hsync      (hsync),
    .vsync      (vsync),
    .blank      (blank),
    .reload     (reload),
    .forceText  (forceText),
    .flashPhase (flashPhase)
  );

  assign hiresOn  = modeReg[2] && !forceText;
  assign isAttr   = (memRspData[6:5] == 2'b00);
  assign flashOff = styleReg[2] && flashPhase;

  ////////////////////////////////////////////////////////////////////////////
  // Address generation
  ////////////////////////////////////////////////////////////////////////////
  assign rowIdx    = hiresOn ? line : {3'b000, line[8:3]};  // Text rows are 8 lines
  assign rowOffset = 16'(rowIdx) * 16'(ROW_BYTES);
  assign scrAddr   = (hiresOn ? HIRES_BASE : TEXT_BASE) + rowOffset + 16'(column);
  assign glyphRow  = styleReg[1] ? line[3:1] : line[2:0];   // Double height halves rate

  always_comb begin
    case ({modeReg[2], styleReg[0]})
      2'b11:   charBase = CHARSET_HIRES_ALT;
      2'b10:   charBase = CHARSET_HIRES_STD;
      2'b01:   charBase = CHARSET_TEXT_ALT;
      default: charBase = CHARSET_TEXT_STD;
    endcase
  end

  assign glyphAddr   = charBase + {6'b0, scrByte[6:0], 3'b000} + {13'b0, glyphRow};
  assign memReq.addr = (state == ST_GLY_REQ) ? glyphAddr : scrAddr;
  assign memReqValid = ((state == ST_CELL) && !blank) || (state == ST_GLY_REQ);

  ////////////////////////////////////////////////////////////////////////////
  // Fetch sequencing and attribute registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      state    <= ST_CELL;
      inkReg   <= '1;                    // White ink
      paperReg <= '0;
      styleReg <= '0;
      modeReg  <= '0;
    end else begin
      case (state)
        ST_CELL: if (!blank && memReqReady) state <= ST_SCR_WAIT;
        ST_SCR_WAIT: begin
          if (memRspValid) begin
            if (isAttr) begin
              case (memRspData[4:3])      // Bits 6:5 are zero here
                2'd0:    inkReg   <= {memRspData[0], memRspData[1], memRspData[2]};
                2'd1:    styleReg <= memRspData[2:0];
                2'd2:    paperReg <= {memRspData[0], memRspData[1], memRspData[2]};
                default: modeReg  <= memRspData[2:0];
              endcase
            end
            state <= (isAttr || hiresOn) ? ST_OFFER : ST_GLY_REQ;
          end
        end
        ST_GLY_REQ:  if (memReqReady) state <= ST_GLY_WAIT;
        ST_GLY_WAIT: if (memRspValid) state <= ST_OFFER;
        default:     if (cellInReady) state <= ST_CELL;
      endcase
      // Line end reload, mode survives
      if (step && reload) begin
        inkReg   <= '1;
        paperReg <= '0;
        styleReg <= '0;
      end
    end
  end

  // Cell payload
  always_ff @(posedge CLK_24) begin
    if ((state == ST_SCR_WAIT) && memRspValid) begin
      scrByte <= memRspData;
      patReg  <= (isAttr || flashOff) ? 6'd0 : memRspData[5:0];  // Hires bits direct
    end else if ((state == ST_GLY_WAIT) && memRspValid) begin
      patReg  <= flashOff ? 6'd0 : memRspData[5:0];
    end
  end

  always_comb begin
    cellIn.pattern = (state == ST_OFFER) ? patReg : '0;  // Blank cells carry no pattern
    cellIn.ink     = inkReg;
    cellIn.paper   = paperReg;
    cellIn.inverse = (state == ST_OFFER) && scrByte[7];  // Screen byte bit 7
    cellIn.hsync   = hsync;
    cellIn.vsync   = vsync;
    cellIn.blank   = blank;
  end

  assign cellInValid = (state == ST_OFFER) || ((state == ST_CELL) && blank);

endmodule

`default_nettype wire

/* source/cellFifo.sv */
`timescale 1ns/100ps
`default_nettype none

module cellFifo
  import ulaVideoPkg::*;
#(
  parameter int DEPTH = 4                // Power of two
) (
  input  wire        CLK_24,
  input  wire        RESET_INT,
  input  wire  cellT cellIn,
  input  wire        cellInValid,
  output logic       cellInReady,
  output cellT       cellOut,
  output logic       cellOutValid,
  input  wire        cellOutReady
);

  localparam int               PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0]   FULL  = (PTR_W + 1)'(DEPTH);

  cellT             mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0]   count;              // Entries held
  logic             wrEn;
  logic             rdEn;

  assign cellInReady  = (count != FULL);
  assign cellOutValid = (count != '0);
  assign wrEn         = cellInValid && cellInReady;
  assign rdEn         = cellOutValid && cellOutReady;
  assign cellOut      = mem[rdPtr];     // Oldest entry

  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) wrPtr <= wrPtr + 1'b1;  // Natural wrap
      if (rdEn) rdPtr <= rdPtr + 1'b1;
      case ({wrEn, rdEn})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK_24) begin
    if (wrEn) mem[wrPtr] <= cellIn;
  end

endmodule

`default_nettype wire

/* source/pixelSerializer.sv */
`timescale 1ns/100ps
`default_nettype none

module pixelSerializer
  import ulaVideoPkg::*;
(
  input  wire        CLK_24,
  input  wire        RESET_INT,
  input  wire  cellT cellOut,
  input  wire        cellOutValid,
  output logic       cellOutReady,
  output pixelT      pixel,
  output logic       pixelValid,
  input  wire        pixelReady
);

  localparam int IDX_W = $clog2(PIXELS_PER_CELL);

  cellT             cellReg;             // Pattern shifts left per pixel
  logic [IDX_W-1:0] pixIdx;
  logic             lastPix;
  logic             take;
  logic             advance;
  rgbT              color;

  assign lastPix      = (pixIdx == IDX_W'(PIXELS_PER_CELL - 1));
  assign advance      = pixelValid && pixelReady;
  // Next record loads as the sixth pixel leaves
  assign cellOutReady = !pixelValid || (pixelReady && lastPix);
  assign take         = cellOutValid && cellOutReady;

  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      pixelValid <= 1'b0;
      pixIdx     <= '0;
    end else if (take) begin
      pixelValid <= 1'b1;
      pixIdx     <= '0;
    end else if (advance) begin
      if (lastPix) pixelValid <= 1'b0;  // Ran dry
      else pixIdx <= pixIdx + 1'b1;
    end
  end

  always_ff @(posedge CLK_24) begin
    if (take) cellReg <= cellOut;
    else if (advance) cellReg.pattern <= cellReg.pattern << 1;
  end

  // Ink on set bits, whole colour flipped for inverse
  assign color     = cellReg.pattern[PIXELS_PER_CELL-1] ? cellReg.ink : cellReg.paper;
  assign pixel.rgb = cellReg.inverse ? ~color : color;
  assign pixel.hsync = cellReg.hsync;
  assign pixel.vsync = cellReg.vsync;
  assign pixel.blank = cellReg.blank;

endmodule

`default_nettype wire

/* source/ulaVideoTop.sv */
`timescale 1ns/100ps
`default_nettype none

module ulaVideoTop
  import ulaVideoPkg::*, ulaMemPkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire        CLK_24,
  input  wire        RESET_INT,
  // Video memory
  output memReqT     memReq,
  output logic       memReqValid,
  input  wire        memReqReady,
  input  wire        memRspValid,
  input  wire  [7:0] memRspData,
  // Pixel stream
  output pixelT      pixel,
  output logic       pixelValid,
  input  wire        pixelReady
);

  cellT cellIn;                          // Producer side
  logic cellInValid;
  logic cellInReady;
  cellT cellOut;                         // Consumer side
  logic cellOutValid;
  logic cellOutReady;

  cellFetcher u_fetcher (
    .CLK_24 (CLK_24), .RESET_INT (RESET_INT),
    .memReq (memReq), .memReqValid (memReqValid), .memReqReady (memReqReady),
    .memRspValid (memRspValid), .memRspData (memRspData),
    .cellIn (cellIn), .cellInValid (cellInValid), .cellInReady (cellInReady)
  );

  cellFifo #(.DEPTH (FIFO_DEPTH)) u_fifo (
    .CLK_24 (CLK_24), .RESET_INT (RESET_INT),
    .cellIn (cellIn), .cellInValid (cellInValid), .cellInReady (cellInReady),
    .cellOut (cellOut), .cellOutValid (cellOutValid), .cellOutReady (cellOutReady)
  );

  pixelSerializer u_serializer (
    .CLK_24 (CLK_24), .RESET_INT (RESET_INT),
    .cellOut (cellOut), .cellOutValid (cellOutValid), .cellOutReady (cellOutReady),
    .pixel (pixel), .pixelValid (pixelValid), .pixelReady (pixelReady)
  );

endmodule

`default_nettype wire

/* verif/ulaVideoTb.sv */
`timescale 1ns/100ps
`default_nettype none

module ulaVideoTb
  import ulaVideoPkg::*, ulaMemPkg::*;
;

  localparam int WATCHDOG_NS = 20 * 313 * 64 * 6 * 3 * 4;  // 20 long frames, slow pixels

  logic        CLK_24;
  logic        RESET_INT;
  memReqT      memReq;
  logic        memReqValid;
  logic        memReqReady;
  logic        memRspValid;
  logic [7:0]  memRspData;
  pixelT       pixel;
  logic        pixelValid;
  logic        pixelReady;

  logic [7:0]  mem [65536];             // Video memory image
  logic [31:0] lfsr;
  logic        busy;                    // Request in flight
  int          waitCnt;
  logic [15:0] pendAddr;

  // Expected pixels, ascending raster order
  int          expFrame[$];
  int          expLine[$];
  int          expCol[$];
  int          expPix[$];
  logic [2:0]  expRgb[$];
  int          expIdx;
  int          lastLine;
  int          curFrame, curLine, curCol, curPix;
  int          valueErrors, otherErrors;
  bit          allChecked;

  ulaVideoTop #(.FIFO_DEPTH (4)) u_dut (
    .CLK_24 (CLK_24), .RESET_INT (RESET_INT),
    .memReq (memReq), .memReqValid (memReqValid), .memReqReady (memReqReady),
    .memRspValid (memRspValid), .memRspData (memRspData),
    .pixel (pixel), .pixelValid (pixelValid), .pixelReady (pixelReady)
  );

  always #2 CLK_24 = ~CLK_24;           // 4 ns period

  // Galois LFSR, one step per bit
  function automatic logic nextRandBit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic longint rasterKey(int f, int l, int c, int p);
    return ((longint'(f) * (lastLine + 1) + l) * 64 + c) * 6 + p;
  endfunction

  task automatic loadGolden();
    int    fd;
    string textLine;
    byte   kind;
    int    a, b, c, d;
    logic [2:0] rgb;
    fd = $fopen("verif/ulaGolden.txt", "r");
    if (fd == 0) begin
      $display("Golden file verif/ulaGolden.txt could not be opened");
      otherErrors++;
      return;
    end
    while ($fgets(textLine, fd) != 0) begin
      if (textLine.len() < 2) continue;
      kind = textLine[0];
      if (kind == "M") begin                               // Memory byte
        void'($sscanf(textLine, "%c %h %h", kind, a, b));
        mem[a] = b[7:0];
      end else if (kind == "L") begin                      // Last line of a frame
        void'($sscanf(textLine, "%c %d", kind, a));
        lastLine = a;
      end else if (kind == "E") begin                      // Expected pixel
        void'($sscanf(textLine, "%c %d %d %d %d %h", kind, a, b, c, d, rgb));
        expFrame.push_back(a);
        expLine.push_back(b);
        expCol.push_back(c);
        expPix.push_back(d);
        expRgb.push_back(rgb);
      end
    end
    $fclose(fd);
  endtask

  task automatic valueError(string name, int got, int exp);
    $display("** Error %s frame %0d line %0d col %0d pix %0d: got %h expected %h",
             name, curFrame, curLine, curCol, curPix, got, exp);
    valueErrors++;
  endtask

  // Flags by raster rule, colour from the golden list
  task automatic checkPixel();
    logic   hsExp, vsExp, blankExp;
    int     vsFirst;
    longint here;
    vsFirst  = (lastLine == LAST_LINE_50) ? VSYNC_50 : VSYNC_60;
    hsExp    = (curCol >= HSYNC_FIRST) && (curCol <= HSYNC_LAST);
    vsExp    = (curLine >= vsFirst) && (curLine < vsFirst + VSYNC_LINES);
    blankExp = (curCol < VISIBLE_FIRST) || (curCol > VISIBLE_LAST) ||
               (curLine >= VBLANK_FIRST);
    if (pixel.hsync !== hsExp) valueError("pixel.hsync", pixel.hsync, hsExp);
    if (pixel.vsync !== vsExp) valueError("pixel.vsync", pixel.vsync, vsExp);
    if (pixel.blank !== blankExp) valueError("pixel.blank", pixel.blank, blankExp);
    here = rasterKey(curFrame, curLine, curCol, curPix);
    if (expIdx < expFrame.size()) begin
      if (rasterKey(expFrame[expIdx], expLine[expIdx], expCol[expIdx],
                    expPix[expIdx]) < here) begin
        $display("Golden entry %0d is out of raster order", expIdx);
        otherErrors++;
        expIdx++;
      end else if (rasterKey(expFrame[expIdx], expLine[expIdx], expCol[expIdx],
                             expPix[expIdx]) == here) begin
        if (pixel.rgb !== expRgb[expIdx]) valueError("pixel.rgb", pixel.rgb, expRgb[expIdx]);
        expIdx++;
      end
    end
    if (expIdx >= expFrame.size()) allChecked = 1'b1;
    // Step the raster position
    curPix++;
    if (curPix == PIXELS_PER_CELL) begin
      curPix = 0;
      curCol++;
      if (curCol == CELLS_PER_LINE) begin
        curCol = 0;
        curLine++;
        if (curLine > lastLine) begin
          curLine = 0;
          curFrame++;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and pixel sink, all on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge CLK_24) begin : drive
    logic r0, r1;
    if (!RESET_INT) begin
      r0 = nextRandBit();
      r1 = nextRandBit();
      pixelReady = r0 | r1;                        // Low one cycle in four
      if (pixelValid && pixelReady) checkPixel();  // Transfers on the next rising edge
      memRspValid = 1'b0;
      if (busy) begin
        waitCnt--;
        if (waitCnt == 0) begin
          memRspValid = 1'b1;
          memRspData  = mem[pendAddr];
          busy        = 1'b0;
        end
      end else if (memReqValid && memReqReady) begin
        pendAddr = memReq.addr;
        busy     = 1'b1;
        r0       = nextRandBit();
        r1       = nextRandBit();
        waitCnt  = 1 + {r0, r1};                   // 1 to 4 cycles
      end
    end
  end

  initial begin
    CLK_24      = 1'b0;
    RESET_INT  <= 1'b1;
    memReqReady = 1'b1;                            // One outstanding, never stalls
    memRspValid = 1'b0;
    memRspData  = '0;
    pixelReady  = 1'b0;
    lfsr        = 32'h32d0_4172;
    busy        = 1'b0;
    waitCnt     = 0;
    pendAddr    = '0;
    expIdx      = 0;
    lastLine    = LAST_LINE_60;
    curFrame    = 0;
    curLine     = 0;
    curCol      = 0;
    curPix      = 0;
    valueErrors = 0;
    otherErrors = 0;
    allChecked  = 1'b0;
    for (int i = 0; i < 65536; i++) mem[i] = 8'h00;
    loadGolden();
    if (expFrame.size() == 0) begin
      $display("Golden file holds no expected pixels");
      otherErrors++;
      allChecked = 1'b1;
    end
    repeat (2) @(posedge CLK_24);
    @(negedge CLK_24);
    RESET_INT <= 1'b0;                             // Memory model starts one edge later
    wait (allChecked);
    @(negedge CLK_24);
    $display("Value errors: %0d, other errors: %0d, golden checks done: %0d",
             valueErrors, otherErrors, expIdx);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #WATCHDOG_NS;
    $display("Timeout: pixel stream stopped short at frame %0d line %0d", curFrame, curLine);
    $display("Value errors: %0d, other errors: %0d, golden checks done: %0d",
             valueErrors, otherErrors + 1, expIdx);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/ulaGolden.txt */
// M addr data : memory byte, both hex
// L last : last line of a frame, decimal ; E frame line col pix rgb : decimal, rgb hex
L 312
M BB81 1A
M BB82 41
M BB83 01
M BB84 41
M BB85 14
M BB86 C1
M BBA9 0B
M BBAA 41
M BBD1 0C
M BBD2 41
M B608 0C
M B609 12
M BA0C 3F
M BA0D 21
E 0 0 2 0 0
E 0 0 2 2 7
E 0 0 3 0 0
E 0 0 4 1 0
E 0 0 4 2 4
E 0 0 5 0 1
E 0 0 6 0 6
E 0 0 6 2 3
E 0 0 7 0 1
E 0 1 2 0 0
E 0 1 2 1 7
E 0 1 4 4 4
E 0 8 2 5 7
E 0 9 2 3 7
E 0 10 2 0 7
E 0 10 2 1 0
E 0 16 2 2 7
E 15 16 2 2 7
E 16 16 2 2 0

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ulaVideoTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary -j $(JOBS)
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* vlog.f */
source/ulaVideoPkg.sv
source/ulaMemPkg.sv
source/rasterTimer.sv
source/cellFetcher.sv
source/cellFifo.sv
source/pixelSerializer.sv
source/ulaVideoTop.sv
verif/ulaVideoTb.sv
